/* verilog/rvv_defs.svh */
`ifndef RVV_DEFS_SVH
`define RVV_DEFS_SVH

// machine widths
`define RVV_VLEN 128
`define RVV_NREGS 32
`define RVV_XLEN 32

// major opcodes
`define RVV_OP_V 7'b1010111
`define RVV_OP_LOAD 7'b0000111
`define RVV_OP_STORE 7'b0100111

// funct3 of OP-V
`define RVV_F3_IVV 3'b000
`define RVV_F3_IVI 3'b011
`define RVV_F3_IVX 3'b100
`define RVV_F3_CFG 3'b111

`define RVV_F6_VMV 6'b010111 // vmv.v.* / vmerge

// memory width code, 32-bit elements
`define RVV_W_E32 3'b110

`endif

/* verilog/rvv_pkg.sv */
`include "rvv_defs.svh"

package rvv_pkg;

	// core to coprocessor
	typedef struct packed {
		logic valid;
		logic [`RVV_XLEN-1:0] insn;
		logic [`RVV_XLEN-1:0] rs1;
		logic [`RVV_XLEN-1:0] rs2;
	} pcpi_req_t;

	typedef struct packed {
		logic wr;
		logic [`RVV_XLEN-1:0] rd;
		logic waiting; // pcpi wait
		logic ready;
	} pcpi_rsp_t;

	typedef struct packed {
		logic req; // one-cycle pulse
		logic we;
		logic [`RVV_XLEN-1:0] addr;
		logic [`RVV_XLEN-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic done; // one pulse per req
		logic [`RVV_XLEN-1:0] rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic vill;
		logic vma;
		logic vta;
		logic [2:0] vsew;
		logic [2:0] vlmul;
	} vtype_t;

	typedef enum logic [2:0] {VOP_NONE, VOP_CFG, VOP_LOAD, VOP_STORE, VOP_MOVE} vop_e;
	typedef enum logic [1:0] {SRC_VV, SRC_VX, SRC_VI} vsrc_e;
	typedef enum logic [1:0] {CFG_VLI, CFG_IVLI, CFG_VL} cfg_kind_e;
	typedef enum logic [2:0] {SEQ_IDLE, SEQ_ISSUE, SEQ_WAIT, SEQ_MOVE, SEQ_DONE} seq_state_e;

	typedef struct packed {
		vop_e op;
		cfg_kind_e cfg_kind;
		vsrc_e src;
		logic [4:0] vd; // also rd of vset*
		logic [4:0] vs1; // also rs1 field
		logic [4:0] vs2;
		logic [4:0] imm5;
		logic [7:0] zimm; // vma, vta, vsew, vlmul
	} dec_t;

endpackage

/* verilog/rvv_decoder.sv */
`timescale 1ns/1ps
`include "rvv_defs.svh"

module rvv_decoder (
	input logic [`RVV_XLEN-1:0] insn_i,
	output rvv_pkg::dec_t dec_o,
	output logic is_rvv_o
);
	import rvv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [5:0] funct6;
	logic [1:0] mop;
	logic [4:0] lumop;
	logic [2:0] nf;
	logic mew;
	logic vm;

	assign opcode = insn_i[6:0];
	assign funct3 = insn_i[14:12]; // width for loads and stores
	assign funct6 = insn_i[31:26];
	assign mop = insn_i[27:26];
	assign lumop = insn_i[24:20]; // sumop on stores
	assign nf = insn_i[31:29];
	assign mew = insn_i[28];
	assign vm = insn_i[25];

	always_comb begin
		dec_o.op = VOP_NONE;
		dec_o.cfg_kind = CFG_VLI;
		dec_o.src = SRC_VV;
		dec_o.vd = insn_i[11:7];
		dec_o.vs1 = insn_i[19:15];
		dec_o.vs2 = insn_i[24:20];
		dec_o.imm5 = insn_i[19:15];
		dec_o.zimm = insn_i[27:20];

		if (opcode == `RVV_OP_V && funct3 == `RVV_F3_CFG) begin
			dec_o.op = VOP_CFG;
			if (!insn_i[31])
				dec_o.cfg_kind = CFG_VLI;
			else if (insn_i[31:30] == 2'b11)
				dec_o.cfg_kind = CFG_IVLI;
			else if (insn_i[31:25] == 7'b1000000)
				dec_o.cfg_kind = CFG_VL;
			else
				dec_o.op = VOP_NONE;
		end else if (opcode == `RVV_OP_V && funct6 == `RVV_F6_VMV && vm && lumop == 5'd0) begin
			// vmv.v.* needs vs2 = 0, anything else here is vmerge
			case (funct3)
				`RVV_F3_IVV: begin
					dec_o.op = VOP_MOVE;
					dec_o.src = SRC_VV;
				end
				`RVV_F3_IVX: begin
					dec_o.op = VOP_MOVE;
					dec_o.src = SRC_VX;
				end
				`RVV_F3_IVI: begin
					dec_o.op = VOP_MOVE;
					dec_o.src = SRC_VI;
				end
				default: dec_o.op = VOP_NONE;
			endcase
		end else if ((opcode == `RVV_OP_LOAD || opcode == `RVV_OP_STORE) &&
				funct3 == `RVV_W_E32 && mop == 2'b00 && lumop == 5'd0 &&
				vm && nf == 3'd0 && !mew) begin
			dec_o.op = (opcode == `RVV_OP_LOAD) ? VOP_LOAD : VOP_STORE; // unit stride only
		end
	end

	assign is_rvv_o = dec_o.op != VOP_NONE;

endmodule

/* verilog/rvv_config.sv */
`timescale 1ns/1ps
`include "rvv_defs.svh"

module rvv_config (
	input logic clk,
	input logic resetn,
	input logic start_i,
	input rvv_pkg::dec_t dec_i,
	input logic [`RVV_XLEN-1:0] rs1_i,
	input logic [`RVV_XLEN-1:0] rs2_i,
	output rvv_pkg::vtype_t vtype_o,
	output logic [`RVV_XLEN-1:0] vl_o,
	output logic done_o
);
	import rvv_pkg::*;

	logic cfg_go;
	vtype_t vtype_nxt;
	logic [`RVV_XLEN-1:0] base; // elements per register at new sew
	logic [`RVV_XLEN-1:0] vlmax;
	logic [`RVV_XLEN-1:0] avl;
	logic [`RVV_XLEN-1:0] vl_nxt;

	assign cfg_go = start_i && dec_i.op == VOP_CFG;

	always_comb begin
		vtype_nxt = '0;
		if (dec_i.cfg_kind == CFG_VL) begin
			vtype_nxt.vma = rs2_i[7];
			vtype_nxt.vta = rs2_i[6];
			vtype_nxt.vsew = rs2_i[5:3];
			vtype_nxt.vlmul = rs2_i[2:0];
		end else begin
			{vtype_nxt.vma, vtype_nxt.vta, vtype_nxt.vsew, vtype_nxt.vlmul} = dec_i.zimm;
		end

		base = `RVV_XLEN'(`RVV_VLEN) >> (vtype_nxt.vsew + 3);
		case (vtype_nxt.vlmul)
			3'b100: vlmax = '0; // reserved lmul
			3'b101, 3'b110, 3'b111: vlmax = base >> (4'd8 - {1'b0, vtype_nxt.vlmul});
			default: vlmax = base << vtype_nxt.vlmul;
		endcase

		// avl source
		if (dec_i.cfg_kind == CFG_IVLI)
			avl = `RVV_XLEN'(dec_i.imm5);
		else if (dec_i.vs1 != 5'd0)
			avl = rs1_i;
		else if (dec_i.vd != 5'd0)
			avl = '1; // request vlmax
		else
			avl = vl_o; // keep vl

		vl_nxt = (avl < vlmax) ? avl : vlmax;
		if (vlmax == '0) begin
			vtype_nxt = '0;
			vtype_nxt.vill = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			vtype_o <= '{vill: 1'b1, vma: 1'b0, vta: 1'b0, vsew: 3'd0, vlmul: 3'd0};
			vl_o <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= cfg_go;
			if (cfg_go) begin
				vtype_o <= vtype_nxt;
				vl_o <= vl_nxt;
			end
		end
	end

endmodule

/* verilog/rvv_vregs.sv */
`timescale 1ns/1ps
`include "rvv_defs.svh"

module rvv_vregs (
	input logic clk,
	input logic we_i,
	input logic [4:0] waddr_i,
	input logic [`RVV_VLEN-1:0] wdata_i,
	input logic [4:0] raddr_a_i,
	input logic [4:0] raddr_b_i,
	output logic [`RVV_VLEN-1:0] rdata_a_o,
	output logic [`RVV_VLEN-1:0] rdata_b_o
);

	logic [`RVV_VLEN-1:0] regs_q [`RVV_NREGS];

	always_ff @(posedge clk) begin
		if (we_i)
			regs_q[waddr_i] <= wdata_i;
	end

	// reads see the old value during a write
	assign rdata_a_o = regs_q[raddr_a_i];
	assign rdata_b_o = regs_q[raddr_b_i];

endmodule

/* verilog/rvv_seq.sv */
`timescale 1ns/1ps
`include "rvv_defs.svh"

module rvv_seq (
	input logic clk,
	input logic resetn,
	input logic start_i,
	input rvv_pkg::dec_t dec_i,
	input logic [`RVV_XLEN-1:0] rs1_i,
	input rvv_pkg::vtype_t vtype_i,
	input logic [`RVV_XLEN-1:0] vl_i,
	output rvv_pkg::mem_req_t mem_req_o,
	input rvv_pkg::mem_rsp_t mem_rsp_i,
	output logic we_o,
	output logic [4:0] waddr_o,
	output logic [`RVV_VLEN-1:0] wdata_o,
	output logic [4:0] raddr_a_o,
	output logic [4:0] raddr_b_o,
	input logic [`RVV_VLEN-1:0] rdata_a_i,
	input logic [`RVV_VLEN-1:0] rdata_b_i,
	output logic busy_o,
	output logic done_o
);
	import rvv_pkg::*;

	localparam int CW = $clog2(`RVV_VLEN) + 1; // holds vl up to vlmax

	seq_state_e state_q;
	logic [CW-1:0] idx_q; // element index, loads and stores
	logic [CW-1:0] rem_q; // elements left, moves
	logic [4:0] reg_cnt_q; // register within group, moves
	logic is_vec;
	logic is_move;
	logic [1:0] sew_sh; // sew clipped to e32
	logic [CW-1:0] epr; // elements per register
	logic last_elem;
	logic last_reg;
	logic [4:0] elem_reg;
	logic [1:0] lane;
	logic [31:0] nbits;
	logic [`RVV_XLEN-1:0] scalar;
	logic [`RVV_VLEN-1:0] rep;
	logic [`RVV_VLEN-1:0] src;
	logic [`RVV_VLEN-1:0] tail_mask;
	logic [`RVV_VLEN-1:0] move_data;
	logic [`RVV_VLEN-1:0] load_data;

	assign is_vec = dec_i.op inside {VOP_LOAD, VOP_STORE, VOP_MOVE};
	assign is_move = dec_i.op == VOP_MOVE;
	assign sew_sh = (vtype_i.vsew > 3'd2) ? 2'd2 : vtype_i.vsew[1:0];
	assign epr = CW'(`RVV_VLEN >> (sew_sh + 3));

	// e32 element idx lives in vd + idx/4, lane idx%4
	assign elem_reg = dec_i.vd + 5'(idx_q >> 2);
	assign lane = idx_q[1:0];
	assign last_elem = (`RVV_XLEN'(idx_q) + 1) == vl_i;
	assign last_reg = rem_q <= epr;

	assign mem_req_o.req = state_q == SEQ_ISSUE;
	assign mem_req_o.we = dec_i.op == VOP_STORE;
	assign mem_req_o.addr = rs1_i + (`RVV_XLEN'(idx_q) << 2);
	assign mem_req_o.wdata = rdata_a_i[{lane, 5'd0} +: 32];

	// ones below the elements still to write; wide shift clears to all ones
	assign nbits = 32'(rem_q) << (sew_sh + 3);
	assign tail_mask = ~({`RVV_VLEN{1'b1}} << nbits);

	always_comb begin
		scalar = (dec_i.src == SRC_VI) ? {{(`RVV_XLEN-5){dec_i.imm5[4]}}, dec_i.imm5} : rs1_i;
		case (sew_sh)
			2'd0: rep = {(`RVV_VLEN/8){scalar[7:0]}};
			2'd1: rep = {(`RVV_VLEN/16){scalar[15:0]}};
			default: rep = {(`RVV_VLEN/32){scalar[31:0]}};
		endcase
		src = (dec_i.src == SRC_VV) ? rdata_a_i : rep;
		move_data = (src & tail_mask) | (rdata_b_i & ~tail_mask); // tail undisturbed

		load_data = rdata_b_i;
		load_data[{lane, 5'd0} +: 32] = mem_rsp_i.rdata;
	end

	// port a sources data, port b is the destination being modified
	assign raddr_a_o = is_move ? dec_i.vs1 + reg_cnt_q : elem_reg;
	assign raddr_b_o = is_move ? dec_i.vd + reg_cnt_q : elem_reg;
	assign waddr_o = raddr_b_o;
	assign we_o = state_q == SEQ_MOVE ||
		(state_q == SEQ_WAIT && mem_rsp_i.done && dec_i.op == VOP_LOAD);
	assign wdata_o = (state_q == SEQ_MOVE) ? move_data : load_data;

	assign busy_o = state_q != SEQ_IDLE;
	assign done_o = state_q == SEQ_DONE;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state_q <= SEQ_IDLE;
			idx_q <= '0;
			rem_q <= '0;
			reg_cnt_q <= '0;
		end else begin
			case (state_q)
				SEQ_IDLE: begin
					if (start_i && is_vec) begin
						idx_q <= '0;
						reg_cnt_q <= '0;
						rem_q <= vl_i[CW-1:0];
						if (vl_i == '0)
							state_q <= SEQ_DONE; // nothing to do
						else if (is_move)
							state_q <= SEQ_MOVE;
						else
							state_q <= SEQ_ISSUE;
					end
				end
				SEQ_ISSUE: state_q <= SEQ_WAIT;
				SEQ_WAIT: begin
					if (mem_rsp_i.done) begin
						if (last_elem) begin
							state_q <= SEQ_DONE;
						end else begin
							idx_q <= idx_q + 1'b1;
							state_q <= SEQ_ISSUE;
						end
					end
				end
				SEQ_MOVE: begin
					reg_cnt_q <= reg_cnt_q + 1'b1;
					rem_q <= rem_q - epr;
					if (last_reg)
						state_q <= SEQ_DONE;
				end
				default: state_q <= SEQ_IDLE; // done pulse shown for one cycle
			endcase
		end
	end

endmodule

/* verilog/rvv_coproc.sv */
`timescale 1ns/1ps
`include "rvv_defs.svh"

module rvv_coproc (
	input logic clk,
	input logic resetn,
	input rvv_pkg::pcpi_req_t pcpi_req_i,
	output rvv_pkg::pcpi_rsp_t pcpi_rsp_o,
	output logic is_rvv_o,
	output rvv_pkg::mem_req_t mem_req_o,
	input rvv_pkg::mem_rsp_t mem_rsp_i
);
	import rvv_pkg::*;

	dec_t dec;
	vtype_t vtype;
	logic [`RVV_XLEN-1:0] vl;
	logic start;
	logic cfg_done;
	logic seq_done;
	logic seq_busy;
	logic vr_we;
	logic [4:0] vr_waddr;
	logic [4:0] vr_raddr_a;
	logic [4:0] vr_raddr_b;
	logic [`RVV_VLEN-1:0] vr_wdata;
	logic [`RVV_VLEN-1:0] vr_rdata_a;
	logic [`RVV_VLEN-1:0] vr_rdata_b;

	// one start per instruction, core holds valid until it sees ready
	assign start = pcpi_req_i.valid && is_rvv_o && !seq_busy && !pcpi_rsp_o.ready;

	// both done sources are flops
	assign pcpi_rsp_o.ready = cfg_done | seq_done;
	assign pcpi_rsp_o.wr = cfg_done;
	assign pcpi_rsp_o.rd = vl;
	assign pcpi_rsp_o.waiting = seq_busy & ~seq_done;

	rvv_decoder u_dec (
		.insn_i(pcpi_req_i.insn),
		.dec_o(dec),
		.is_rvv_o(is_rvv_o)
	);

	rvv_config u_cfg (
		.clk(clk),
		.resetn(resetn),
		.start_i(start),
		.dec_i(dec),
		.rs1_i(pcpi_req_i.rs1),
		.rs2_i(pcpi_req_i.rs2),
		.vtype_o(vtype),
		.vl_o(vl),
		.done_o(cfg_done)
	);

	rvv_vregs u_vregs (
		.clk(clk),
		.we_i(vr_we),
		.waddr_i(vr_waddr),
		.wdata_i(vr_wdata),
		.raddr_a_i(vr_raddr_a),
		.raddr_b_i(vr_raddr_b),
		.rdata_a_o(vr_rdata_a),
		.rdata_b_o(vr_rdata_b)
	);

	rvv_seq u_seq (
		.clk(clk),
		.resetn(resetn),
		.start_i(start),
		.dec_i(dec),
		.rs1_i(pcpi_req_i.rs1),
		.vtype_i(vtype),
		.vl_i(vl),
		.mem_req_o(mem_req_o),
		.mem_rsp_i(mem_rsp_i),
		.we_o(vr_we),
		.waddr_o(vr_waddr),
		.wdata_o(vr_wdata),
		.raddr_a_o(vr_raddr_a),
		.raddr_b_o(vr_raddr_b),
		.rdata_a_i(vr_rdata_a),
		.rdata_b_i(vr_rdata_b),
		.busy_o(seq_busy),
		.done_o(seq_done)
	);

endmodule

/* dv/rvv_checker.sv */
`timescale 1ns/1ps
`include "rvv_defs.svh"

module rvv_checker (
	input logic clk,
	input logic resetn,
	input rvv_pkg::pcpi_rsp_t pcpi_rsp_i,
	input rvv_pkg::mem_req_t mem_req_i,
	input rvv_pkg::mem_rsp_t mem_rsp_i
);

	int fail_cnt = 0; // read by the testbench at the end
	logic outstanding_q; // a req is waiting for its done

	always_ff @(posedge clk) begin
		if (!resetn)
			outstanding_q <= 1'b0;
		else if (mem_req_i.req)
			outstanding_q <= 1'b1;
		else if (mem_rsp_i.done)
			outstanding_q <= 1'b0;
	end

	ready_pulse: assert property (@(posedge clk) disable iff (!resetn)
		pcpi_rsp_i.ready |=> !pcpi_rsp_i.ready)
		else begin
			$error("ready held high for more than one cycle");
			fail_cnt++;
		end

	wr_with_ready: assert property (@(posedge clk) disable iff (!resetn)
		pcpi_rsp_i.wr |-> pcpi_rsp_i.ready)
		else begin
			$error("wr raised without ready");
			fail_cnt++;
		end

	one_outstanding: assert property (@(posedge clk) disable iff (!resetn)
		mem_req_i.req |-> !outstanding_q)
		else begin
			$error("memory req issued before previous done");
			fail_cnt++;
		end

	wait_drops: assert property (@(posedge clk) disable iff (!resetn)
		pcpi_rsp_i.ready |-> !pcpi_rsp_i.waiting)
		else begin
			$error("wait high together with ready");
			fail_cnt++;
		end

endmodule

bind rvv_coproc rvv_checker u_chk (
	.clk(clk),
	.resetn(resetn),
	.pcpi_rsp_i(pcpi_rsp_o),
	.mem_req_i(mem_req_o),
	.mem_rsp_i(mem_rsp_i)
);

/* dv/rvv_monitor.sv */
`timescale 1ns/1ps
`include "rvv_defs.svh"

module rvv_monitor (
	input logic clk,
	input logic resetn,
	input rvv_pkg::pcpi_req_t pcpi_req_i,
	input rvv_pkg::pcpi_rsp_t pcpi_rsp_i,
	input logic is_rvv_i,
	input rvv_pkg::mem_req_t mem_req_i,
	input rvv_pkg::mem_rsp_t mem_rsp_i,
	output int errors_o
);
	import rvv_pkg::*;

	logic [`RVV_VLEN-1:0] m_regs [`RVV_NREGS]; // architectural registers
	logic [2:0] m_sew;
	logic [31:0] m_vl;
	logic valid_d;
	logic pending;
	vop_e cur_op;
	logic [31:0] insn_q, rs1_q, rs2_q;
	logic [31:0] exp_vl;
	logic [2:0] exp_sew;
	int idx, req_idx;

	initial errors_o = 0;

	task automatic report(input string msg);
		$display("[FAIL] %0t %s", $time, msg);
		errors_o++;
	endtask

	// instruction forms the coprocessor takes
	function automatic logic claims(input logic [31:0] insn);
		logic [2:0] f3;
		f3 = insn[14:12];
		if (insn[6:0] == `RVV_OP_V && f3 == `RVV_F3_CFG)
			return !insn[31] || insn[31:30] == 2'b11 || insn[31:25] == 7'b1000000;
		if (insn[6:0] == `RVV_OP_V)
			return insn[31:26] == `RVV_F6_VMV && insn[25] && insn[24:20] == 5'd0 &&
				(f3 == `RVV_F3_IVV || f3 == `RVV_F3_IVX || f3 == `RVV_F3_IVI);
		if (insn[6:0] == `RVV_OP_LOAD || insn[6:0] == `RVV_OP_STORE)
			return f3 == `RVV_W_E32 && insn[31:20] == 12'b000000100000; // unit stride, vm=1
		return 1'b0;
	endfunction

	// vl after a vset* per the configuration rules
	function automatic logic [31:0] cfg_model(input logic [31:0] insn, input logic [31:0] rs1,
			input logic [31:0] rs2, input logic [31:0] old_vl, output logic [2:0] sew);
		logic [7:0] z;
		logic [31:0] base, vlmax, avl;
		z = (insn[31:30] == 2'b10) ? rs2[7:0] : insn[27:20];
		sew = z[5:3];
		base = 32'(`RVV_VLEN) >> (z[5:3] + 3);
		if (z[2:0] == 3'b100)
			vlmax = 0;
		else if (z[2])
			vlmax = base >> (8 - z[2:0]); // fractional
		else
			vlmax = base << z[2:0];
		if (insn[31:30] == 2'b11)
			avl = 32'(insn[19:15]);
		else if (insn[19:15] != 0)
			avl = rs1;
		else if (insn[11:7] != 0)
			avl = '1;
		else
			avl = old_vl;
		return (avl < vlmax) ? avl : vlmax;
	endfunction

	task automatic apply_move();
		int sew, epr, off;
		logic [31:0] val;
		logic [4:0] r, rs;
		sew = 8 << m_sew;
		epr = `RVV_VLEN / sew;
		val = (insn_q[14:12] == `RVV_F3_IVI) ? {{27{insn_q[19]}}, insn_q[19:15]} : rs1_q;
		for (int e = 0; e < int'(m_vl); e++) begin
			r = insn_q[11:7] + 5'(e / epr);
			rs = insn_q[19:15] + 5'(e / epr);
			off = (e % epr) * sew;
			for (int b = 0; b < sew; b++)
				m_regs[r][off + b] = (insn_q[14:12] == `RVV_F3_IVV) ? m_regs[rs][off + b] : val[b];
		end
	endtask

	always @(posedge clk) begin
		if (!resetn) begin
			valid_d = 1'b0;
			pending = 1'b0;
			m_vl = 0;
			m_sew = 0;
		end else begin
			if (is_rvv_i != claims(pcpi_req_i.insn))
				report($sformatf("is_rvv %0b for %h, expected %0b", is_rvv_i,
					pcpi_req_i.insn, claims(pcpi_req_i.insn)));

			if (pcpi_req_i.valid && !valid_d) begin // new instruction
				insn_q = pcpi_req_i.insn;
				rs1_q = pcpi_req_i.rs1;
				rs2_q = pcpi_req_i.rs2;
				idx = 0;
				pending = 1'b1;
				if (insn_q[6:0] == `RVV_OP_LOAD)
					cur_op = VOP_LOAD;
				else if (insn_q[6:0] == `RVV_OP_STORE)
					cur_op = VOP_STORE;
				else if (insn_q[14:12] == `RVV_F3_CFG)
					cur_op = VOP_CFG;
				else
					cur_op = VOP_MOVE;
				if (cur_op == VOP_CFG)
					exp_vl = cfg_model(insn_q, rs1_q, rs2_q, m_vl, exp_sew);
			end else if (pending && cur_op != VOP_CFG && m_vl != 0 &&
					!pcpi_rsp_i.ready && !pcpi_rsp_i.waiting) begin
				report("wait low during a multi-cycle operation");
			end

			if (mem_req_i.req) begin
				if (!pending || !(cur_op inside {VOP_LOAD, VOP_STORE}) || m_vl == 0) begin
					report("unexpected memory request");
				end else begin
					if (mem_req_i.addr != rs1_q + 32'(idx) * 4)
						report($sformatf("addr %h, expected %h", mem_req_i.addr,
							rs1_q + 32'(idx) * 4));
					if (mem_req_i.we != (cur_op == VOP_STORE))
						report("wrong we on memory request");
					if (cur_op == VOP_STORE &&
							mem_req_i.wdata != m_regs[insn_q[11:7] + 5'(idx / 4)][(idx % 4) * 32 +: 32])
						report($sformatf("store element %0d: got %h, expected %h", idx,
							mem_req_i.wdata,
							m_regs[insn_q[11:7] + 5'(idx / 4)][(idx % 4) * 32 +: 32]));
					req_idx = idx;
					idx++;
				end
			end

			if (mem_rsp_i.done && pending && cur_op == VOP_LOAD)
				m_regs[insn_q[11:7] + 5'(req_idx / 4)][(req_idx % 4) * 32 +: 32] = mem_rsp_i.rdata;

			if (pcpi_rsp_i.ready) begin
				if (!pending) begin
					report("ready without an instruction");
				end else if (cur_op == VOP_CFG) begin
					if (!pcpi_rsp_i.wr || pcpi_rsp_i.rd != exp_vl)
						report($sformatf("vl %0d wr %0b, expected %0d", pcpi_rsp_i.rd,
							pcpi_rsp_i.wr, exp_vl));
					m_vl = exp_vl;
					m_sew = exp_sew;
				end else begin
					if (pcpi_rsp_i.wr)
						report("wr on a non-configuration instruction");
					if (cur_op inside {VOP_LOAD, VOP_STORE} && idx != int'(m_vl))
						report($sformatf("%0d elements transferred, vl %0d", idx, m_vl));
					if (cur_op == VOP_MOVE)
						apply_move();
				end
				pending = 1'b0;
			end
			valid_d = pcpi_req_i.valid;
		end
	end

endmodule

/* dv/rvv_tb.sv */
`timescale 1ns/1ps
`include "rvv_defs.svh"

module rvv_tb;
	import rvv_pkg::*;

	logic clk;
	logic resetn;
	pcpi_req_t pcpi_req;
	pcpi_rsp_t pcpi_rsp;
	logic is_rvv;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;
	logic [31:0] lfsr_q;
	logic [31:0] mem [1024]; // word addressed
	int mon_errors;

	rvv_coproc u_dut (
		.clk(clk),
		.resetn(resetn),
		.pcpi_req_i(pcpi_req),
		.pcpi_rsp_o(pcpi_rsp),
		.is_rvv_o(is_rvv),
		.mem_req_o(mem_req),
		.mem_rsp_i(mem_rsp)
	);

	rvv_monitor u_mon (
		.clk(clk),
		.resetn(resetn),
		.pcpi_req_i(pcpi_req),
		.pcpi_rsp_i(pcpi_rsp),
		.is_rvv_i(is_rvv),
		.mem_req_i(mem_req),
		.mem_rsp_i(mem_rsp),
		.errors_o(mon_errors)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
		end
		return v;
	endfunction

	function automatic logic [31:0] enc_vsetvli(input logic [4:0] rd, input logic [4:0] rs1f,
			input logic [7:0] z);
		return {1'b0, 3'b000, z, rs1f, `RVV_F3_CFG, rd, `RVV_OP_V};
	endfunction

	function automatic logic [31:0] enc_mem(input logic store, input logic [4:0] vd);
		return {12'b000_0_00_1_00000, 5'd1, `RVV_W_E32, vd, store ? `RVV_OP_STORE : `RVV_OP_LOAD};
	endfunction

	function automatic logic [31:0] enc_vmv(input logic [2:0] f3, input logic [4:0] vd,
			input logic [4:0] src);
		return {`RVV_F6_VMV, 1'b1, 5'd0, src, f3, vd, `RVV_OP_V};
	endfunction

	function automatic logic [31:0] rand_base();
		return {20'd0, rand_bits(10), 2'b00};
	endfunction

	function automatic logic [4:0] rand_group(input logic [1:0] lmul);
		return rand_bits(5) & ~((5'd1 << lmul) - 5'd1);
	endfunction

	// hold valid until ready, then drop it for a cycle
	task automatic issue(input logic [31:0] insn, input logic [31:0] rs1, input logic [31:0] rs2);
		int t;
		@(posedge clk);
		pcpi_req <= '{valid: 1'b1, insn: insn, rs1: rs1, rs2: rs2};
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!pcpi_rsp.ready && t < 300);
		if (!pcpi_rsp.ready) begin
			$display("timeout: no ready for instruction %h", insn);
			$display("Verification failed");
			$finish;
		end else begin
			@(posedge clk);
			pcpi_req.valid <= 1'b0;
		end
	endtask

	// words outside the supported set, shown with valid low
	task automatic offer_foreign();
		logic [31:0] w;
		case (rand_bits(2))
			2'd0: w = enc_mem(1'b1, 5'd0) & ~32'h0200_0000; // masked store
			2'd1: w = enc_mem(1'b0, 5'd0) ^ 32'h0000_6000; // e8 load
			2'd2: w = enc_vmv(`RVV_F3_IVX, 5'd2, 5'd3) | 32'h0010_0000; // vmerge, vs2 nonzero
			default: w = {25'(rand_bits(25)), 7'b0110011}; // scalar op
		endcase
		@(posedge clk);
		pcpi_req.insn <= w;
	endtask

	task automatic do_config();
		logic [1:0] kind, sel;
		logic [4:0] rd, rs1f;
		logic [7:0] z;
		logic [31:0] avl;
		kind = 2'(rand_bits(2) % 3);
		sel = rand_bits(2);
		rd = sel[0] ? 5'd1 + 5'(rand_bits(4)) : 5'd0;
		rs1f = sel[1] ? 5'd1 + 5'(rand_bits(4)) : 5'd0;
		z = {rand_bits(2), 1'b0, rand_bits(2), rand_bits(3)}; // sew e8..e64
		avl = rand_bits(7);
		case (kind)
			2'd0: issue(enc_vsetvli(rd, rs1f, z), avl, 0);
			2'd1: issue({2'b11, 2'b00, z, avl[4:0], `RVV_F3_CFG, rd, `RVV_OP_V}, 0, 0);
			default: issue({7'b1000000, 5'd3, rs1f, `RVV_F3_CFG, rd, `RVV_OP_V}, avl, 32'(z));
		endcase
	endtask

	task automatic do_load_store();
		logic [1:0] lmul;
		logic [4:0] vd;
		lmul = rand_bits(2);
		vd = rand_group(lmul);
		issue(enc_vsetvli(5'd1, 5'd2, {2'b00, 3'd2, 1'b0, lmul}), rand_bits(7), 0);
		issue(enc_mem(1'b0, vd), rand_base(), 0);
		issue(enc_mem(1'b1, vd), rand_base(), 0);
	endtask

	task automatic do_move();
		logic [1:0] lmul, sew, kind;
		logic [4:0] vd, src;
		logic [2:0] f3;
		sew = 2'(rand_bits(2) % 3);
		lmul = 2'(rand_bits(2) % 3);
		kind = 2'(rand_bits(2) % 3);
		vd = rand_group(lmul);
		f3 = (kind == 0) ? `RVV_F3_IVV : (kind == 1) ? `RVV_F3_IVX : `RVV_F3_IVI;
		src = (kind == 0) ? rand_group(lmul) : 5'(rand_bits(5));
		issue(enc_vsetvli(5'd1, 5'd2, {2'b00, 1'b0, sew, 1'b0, lmul}), rand_bits(7), 0);
		issue(enc_vmv(f3, vd, src), rand_bits(32), 0);
		// full-width e32 store shows body and tail
		issue(enc_vsetvli(5'd1, 5'd0, {2'b00, 3'd2, 1'b0, lmul}), 0, 0);
		issue(enc_mem(1'b1, vd), rand_base(), 0);
	endtask

	task automatic do_zero_vl();
		logic [1:0] kind;
		kind = 2'(rand_bits(2) % 3);
		issue(enc_vsetvli(5'd1, 5'd2, 8'b00_010_100), 5, 0); // lmul 100, vill
		case (kind)
			2'd0: issue(enc_mem(1'b0, 5'(rand_bits(5))), rand_base(), 0);
			2'd1: issue(enc_mem(1'b1, 5'(rand_bits(5))), rand_base(), 0);
			default: issue(enc_vmv(`RVV_F3_IVX, 5'(rand_bits(5)), 5'd4), rand_bits(32), 0);
		endcase
	endtask

	// memory responder, done after 1 to 6 cycles
	initial begin
		logic [31:0] addr, wdata;
		logic we;
		int delay;
		forever begin
			@(posedge clk);
			if (resetn && mem_req.req) begin
				addr = mem_req.addr;
				we = mem_req.we;
				wdata = mem_req.wdata;
				delay = 1 + int'(rand_bits(3) % 6);
				repeat (delay - 1) @(posedge clk);
				if (we)
					mem[addr[11:2]] = wdata;
				mem_rsp <= '{done: 1'b1, rdata: we ? 32'd0 : mem[addr[11:2]]};
				@(posedge clk);
				mem_rsp.done <= 1'b0;
			end
		end
	end

	initial begin
		lfsr_q = 32'd6693;
		resetn = 1'b0;
		pcpi_req = '0;
		mem_rsp = '0;
		for (int i = 0; i < 1024; i++)
			mem[i] = rand_bits(32) ^ (32'(i) * 32'h9e3779b1);
		repeat (4) @(posedge clk);
		resetn <= 1'b1;

		// fill every register: e32 m8 at vlmax, four groups
		issue(enc_vsetvli(5'd1, 5'd0, 8'b00_010_011), 0, 0);
		for (int g = 0; g < 4; g++)
			issue(enc_mem(1'b0, 5'(g * 8)), rand_base(), 0);

		repeat (80) begin
			case (rand_bits(3) % 5)
				0: do_config();
				1: do_load_store();
				2, 3: do_move();
				default: begin
					offer_foreign();
					do_zero_vl();
				end
			endcase
		end
		repeat (4) @(posedge clk);

		$display("errors: monitor %0d, assertions %0d", mon_errors, u_dut.u_chk.fail_cnt);
		if (mon_errors == 0 && u_dut.u_chk.fail_cnt == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* list.f */
+incdir+verilog
verilog/rvv_pkg.sv
verilog/rvv_decoder.sv
verilog/rvv_config.sv
verilog/rvv_vregs.sv
verilog/rvv_seq.sv
verilog/rvv_coproc.sv
dv/rvv_checker.sv
dv/rvv_monitor.sv
dv/rvv_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= rvv_tb
FILELIST ?= list.f
LOG ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
